//--- hw/rfo_defs.svh
`ifndef RFO_DEFS_SVH
`define RFO_DEFS_SVH

// oscillator
`define RFO_ACC_W           16      // phase accumulator bits

// apb bus
`define RFO_APB_AW          8
`define RFO_APB_DW          32

// register map
`define RFO_ADDR_CTRL       8'h00   // bit0 start, bit1 sweep_en
`define RFO_ADDR_START_INC  8'h04
`define RFO_ADDR_SWEEP_END  8'h08
`define RFO_ADDR_TARGET     8'h0C
`define RFO_ADDR_STATUS     8'h10   // ro, [1:0] mode, [2] locked
`define RFO_ADDR_THETA      8'h14   // ro
`define RFO_ADDR_INC        8'h18   // ro

// lock hysteresis on |theta - target|
`define RFO_LOCK_ENTER      16
`define RFO_LOCK_EXIT       40

`define RFO_SWEEP_STEP      10      // inc added per cycle in sweep
`define RFO_DEAD_CLKS       5       // bridge dead time, clocks

`define RFO_START_INC_RST   1310    // ~200 kHz at 10 MHz
`define RFO_SWEEP_END_RST   1966

`endif

//--- hw/rfo_pkg.sv
package rfo_pkg;

	// operating mode of the tracking core
	typedef enum logic [1:0] {
		MODE_IDLE  = 2'd0,  // bridge off
		MODE_SWEEP = 2'd1,  // open loop ramp up
		MODE_TRACK = 2'd2   // closed loop on theta
	} mode_t;

	// phase metric, clock counts per cycle, +-255 saturated
	typedef logic signed [8:0] theta_t;

	// nco increment
	typedef logic [14:0] inc_t;

endpackage

//--- hw/rfo_apb_regs.sv
`timescale 1ns/1ns
`include "rfo_defs.svh"

module rfo_apb_regs (
	input  logic                   clk10MHz_inv,
	input  logic                   reset,
	input  logic                   psel,
	input  logic                   penable,
	input  logic                   pwrite,
	input  logic [`RFO_APB_AW-1:0] paddr,
	input  logic [`RFO_APB_DW-1:0] pwdata,
	output logic [`RFO_APB_DW-1:0] prdata,
	output logic                   pready,
	output logic                   pslverr,
	input  rfo_pkg::mode_t         mode,
	input  logic                   locked,
	input  rfo_pkg::theta_t        theta,
	input  rfo_pkg::inc_t          inc,
	output logic                   start,
	output logic                   sweep_en,
	output rfo_pkg::inc_t          start_inc,
	output rfo_pkg::inc_t          sweep_end,
	output rfo_pkg::theta_t        target
);
	import rfo_pkg::*;

	localparam int dw      = `RFO_APB_DW;
	localparam int inc_w   = $bits(inc_t);
	localparam int theta_w = $bits(theta_t);

	logic access;   // apb access phase
	logic addr_ok;  // address is mapped
	logic addr_ro;  // status side, no writes

	assign access = psel & penable;
	assign pready = 1'b1;  // zero wait states
	assign pslverr = access & (~addr_ok | (pwrite & addr_ro));

	// read mux and decode
	always_comb begin
		addr_ok = 1'b1;
		addr_ro = 1'b0;
		prdata  = '0;
		case (paddr)
			`RFO_ADDR_CTRL:      prdata = {{(dw-2){1'b0}}, sweep_en, start};
			`RFO_ADDR_START_INC: prdata = {{(dw-inc_w){1'b0}}, start_inc};
			`RFO_ADDR_SWEEP_END: prdata = {{(dw-inc_w){1'b0}}, sweep_end};
			`RFO_ADDR_TARGET:    prdata = {{(dw-theta_w){target[theta_w-1]}}, target};
			`RFO_ADDR_STATUS: begin
				prdata  = {{(dw-3){1'b0}}, locked, mode};
				addr_ro = 1'b1;
			end
			`RFO_ADDR_THETA: begin
				prdata  = {{(dw-theta_w){theta[theta_w-1]}}, theta};  // sign extended
				addr_ro = 1'b1;
			end
			`RFO_ADDR_INC: begin
				prdata  = {{(dw-inc_w){1'b0}}, inc};
				addr_ro = 1'b1;
			end
			default: addr_ok = 1'b0;
		endcase
	end

	// config writes land at end of access phase
	always_ff @(posedge clk10MHz_inv) begin
		if (reset) begin
			start     <= 1'b0;
			sweep_en  <= 1'b0;
			start_inc <= inc_t'(`RFO_START_INC_RST);
			sweep_end <= inc_t'(`RFO_SWEEP_END_RST);
			target    <= '0;
		end else if (access && pwrite) begin
			case (paddr)
				`RFO_ADDR_CTRL: begin
					start    <= pwdata[0];
					sweep_en <= pwdata[1];
				end
				`RFO_ADDR_START_INC: start_inc <= pwdata[inc_w-1:0];
				`RFO_ADDR_SWEEP_END: sweep_end <= pwdata[inc_w-1:0];
				`RFO_ADDR_TARGET:    target    <= pwdata[theta_w-1:0];
				default: ;  // ro or unmapped, flagged by pslverr
			endcase
		end
	end

endmodule

//--- hw/rfo_mode_fsm.sv
`timescale 1ns/1ns

module rfo_mode_fsm (
	input  logic           clk10MHz_inv,
	input  logic           reset,
	input  logic           start,
	input  logic           sweep_en,
	input  logic           fault,
	input  logic           sweep_done,
	output rfo_pkg::mode_t mode,
	output logic           load,
	output logic           bridge_en
);
	import rfo_pkg::*;

	mode_t mode_nxt;
	logic  load_nxt;

	always_comb begin
		mode_nxt = mode;
		load_nxt = 1'b0;
		if (!start || fault) begin
			mode_nxt = MODE_IDLE;  // stop or trip from anywhere
		end else begin
			case (mode)
				MODE_IDLE: begin
					mode_nxt = sweep_en ? MODE_SWEEP : MODE_TRACK;
					load_nxt = 1'b1;  // preset integrator to start_inc
				end
				MODE_SWEEP: begin
					// inc still stale on the load clock
					if (sweep_done && !load)
						mode_nxt = MODE_TRACK;
				end
				MODE_TRACK: mode_nxt = MODE_TRACK;
				default:    mode_nxt = MODE_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk10MHz_inv) begin
		if (reset) begin
			mode <= MODE_IDLE;
			load <= 1'b0;
		end else begin
			mode <= mode_nxt;
			load <= load_nxt;  // one clock pulse
		end
	end

	assign bridge_en = (mode != MODE_IDLE);  // sweep and track switch

endmodule

//--- hw/rfo_nco.sv
`timescale 1ns/1ns
`include "rfo_defs.svh"

module rfo_nco (
	input  logic          clk10MHz_inv,
	input  logic          reset,
	input  rfo_pkg::inc_t inc,
	output logic          cycle
);
	import rfo_pkg::*;

	localparam int acc_w = `RFO_ACC_W;
	localparam int inc_w = $bits(inc_t);

	logic [acc_w-1:0] acc;  // phase, wraps every 2^16/inc clocks

	always_ff @(posedge clk10MHz_inv) begin
		if (reset)
			acc <= '0;
		else
			acc <= acc + {{(acc_w-inc_w){1'b0}}, inc};
	end

	// msb gives a 50 % switching square wave
	assign cycle = acc[acc_w-1];

endmodule

//--- hw/rfo_phase_detect.sv
`timescale 1ns/1ns
`include "rfo_defs.svh"

module rfo_phase_detect (
	input  logic            clk10MHz_inv,
	input  logic            reset,
	input  logic            cycle,
	input  logic            iq,
	input  rfo_pkg::theta_t target,
	output rfo_pkg::theta_t theta,
	output logic            theta_valid,
	output logic            locked
);
	import rfo_pkg::*;

	localparam theta_t sat_pos = 9'sd255;
	localparam theta_t sat_neg = -9'sd255;

	logic        iq_s1;     // sync stage 1
	logic        iq_s2;     // sync stage 2
	logic        cycle_d;   // edge detect
	logic        cycle_d2;  // lines up with iq_s2
	logic        rise_q;    // cycle rise seen
	logic        match;
	theta_t      sum;       // running count this cycle
	theta_t      sum_step;
	logic signed [9:0] err;
	logic [9:0]  err_abs;

	assign match = (iq_s2 == cycle_d2);  // current sign agrees with drive

	// +1 on agreement, -1 otherwise, clamp at +-255
	always_comb begin
		if (match)
			sum_step = (sum == sat_pos) ? sum : sum + 9'sd1;
		else
			sum_step = (sum == sat_neg) ? sum : sum - 9'sd1;
	end

	assign err     = {theta[8], theta} - {target[8], target};
	assign err_abs = err[9] ? -err : err;

	always_ff @(posedge clk10MHz_inv) begin
		if (reset) begin
			iq_s1       <= 1'b0;
			iq_s2       <= 1'b0;
			cycle_d     <= 1'b0;
			cycle_d2    <= 1'b0;
			rise_q      <= 1'b0;
			sum         <= '0;
			theta       <= '0;
			theta_valid <= 1'b0;
			locked      <= 1'b0;
		end else begin
			iq_s1    <= iq;
			iq_s2    <= iq_s1;
			cycle_d  <= cycle;
			cycle_d2 <= cycle_d;
			rise_q   <= cycle & ~cycle_d;
			theta_valid <= rise_q;  // strobe with new theta
			if (rise_q) begin
				theta <= sum;
				sum   <= match ? 9'sd1 : -9'sd1;  // first count of next cycle
			end else begin
				sum <= sum_step;
			end
			// hysteresis, wide exit band
			if (theta_valid) begin
				if (locked)
					locked <= (err_abs < `RFO_LOCK_EXIT);
				else
					locked <= (err_abs < `RFO_LOCK_ENTER);
			end
		end
	end

endmodule

//--- hw/rfo_freq_ctrl.sv
`timescale 1ns/1ns
`include "rfo_defs.svh"

module rfo_freq_ctrl (
	input  logic            clk10MHz_inv,
	input  logic            reset,
	input  rfo_pkg::mode_t  mode,
	input  logic            load,
	input  rfo_pkg::inc_t   start_inc,
	input  rfo_pkg::inc_t   sweep_end,
	input  rfo_pkg::theta_t theta,
	input  rfo_pkg::theta_t target,
	input  logic            theta_valid,
	output rfo_pkg::inc_t   inc,
	output logic            sweep_done
);
	import rfo_pkg::*;

	localparam int int_w   = $bits(inc_t) + 2;  // two fraction bits
	localparam int int_min = 4;                 // inc floor of 1, nco keeps running
	localparam int int_max = 2**int_w - 1;

	logic [int_w-1:0]        integ;
	logic [int_w-1:0]        integ_nxt;
	logic signed [int_w+1:0] step;
	logic signed [int_w+1:0] sum_ext;
	logic signed [10:0]      delta;  // 2 * phase error

	assign delta = {theta[8], theta, 1'b0} - {target[8], target, 1'b0};

	always_comb begin
		case (mode)
			MODE_SWEEP: step = `RFO_SWEEP_STEP * 4;
			MODE_TRACK: step = delta;
			default:    step = '0;
		endcase
		sum_ext = $signed({2'b00, integ}) + step;
		if (sum_ext < int_min)
			integ_nxt = int_w'(int_min);
		else if (sum_ext > int_max)
			integ_nxt = int_w'(int_max);
		else
			integ_nxt = sum_ext[int_w-1:0];
	end

	always_ff @(posedge clk10MHz_inv) begin
		if (reset)
			integ <= {inc_t'(`RFO_START_INC_RST), 2'b00};
		else if (load)
			integ <= {start_inc, 2'b00};
		else if (theta_valid)
			integ <= integ_nxt;  // once per switching cycle
	end

	assign inc        = integ[int_w-1:2];  // drop fraction
	assign sweep_done = (inc >= sweep_end);

endmodule

//--- hw/rfo_gate_drive.sv
`timescale 1ns/1ns
`include "rfo_defs.svh"

module rfo_gate_drive (
	input  logic clk10MHz_inv,
	input  logic reset,
	input  logic cycle,
	input  logic bridge_en,
	output logic gate_ap,
	output logic gate_an,
	output logic gate_bp,
	output logic gate_bn
);
	localparam int dead = `RFO_DEAD_CLKS;

	logic [1:0]           drive;  // [0] leg a, [1] leg b
	logic [1:0][dead-1:0] dly;    // per leg delay line
	logic [1:0]           hi_q;
	logic [1:0]           lo_q;

	assign drive = {~cycle, cycle};  // legs in antiphase

	// a gate turns on only when live and delayed command agree
	always_ff @(posedge clk10MHz_inv) begin
		if (reset) begin
			dly  <= '0;
			hi_q <= '0;
			lo_q <= '0;
		end else begin
			for (int leg = 0; leg < 2; leg++) begin
				dly[leg]  <= {dly[leg][dead-2:0], drive[leg]};
				hi_q[leg] <= drive[leg] & dly[leg][dead-1];
				lo_q[leg] <= ~drive[leg] & ~dly[leg][dead-1];
			end
		end
	end

	// bridge off forces all four low at once
	assign gate_ap = hi_q[0] & bridge_en;
	assign gate_an = lo_q[0] & bridge_en;
	assign gate_bp = hi_q[1] & bridge_en;
	assign gate_bn = lo_q[1] & bridge_en;

endmodule

//--- hw/rfo_top.sv
`timescale 1ns/1ns
`include "rfo_defs.svh"

module rfo_top (
	input  logic                   clk10MHz_inv,
	input  logic                   reset,
	input  logic                   psel,
	input  logic                   penable,
	input  logic                   pwrite,
	input  logic [`RFO_APB_AW-1:0] paddr,
	input  logic [`RFO_APB_DW-1:0] pwdata,
	output logic [`RFO_APB_DW-1:0] prdata,
	output logic                   pready,
	output logic                   pslverr,
	input  logic                   iq,        // sampled current sign
	input  logic                   fault,
	output logic                   gate_ap,
	output logic                   gate_an,
	output logic                   gate_bp,
	output logic                   gate_bn,
	output logic                   locked
);
	import rfo_pkg::*;

	logic   start;
	logic   sweep_en;
	inc_t   start_inc;
	inc_t   sweep_end;
	theta_t target;
	mode_t  mode;
	logic   load;
	logic   bridge_en;
	logic   cycle;        // switching square wave
	theta_t theta;
	logic   theta_valid;
	inc_t   inc;
	logic   sweep_done;

	rfo_apb_regs apb_regs_inst (
		.clk10MHz_inv, .reset,
		.psel, .penable, .pwrite, .paddr, .pwdata,
		.prdata, .pready, .pslverr,
		.mode, .locked, .theta, .inc,
		.start, .sweep_en, .start_inc, .sweep_end, .target
	);

	rfo_mode_fsm mode_fsm_inst (
		.clk10MHz_inv, .reset,
		.start, .sweep_en, .fault, .sweep_done,
		.mode, .load, .bridge_en
	);

	rfo_nco nco_inst (.clk10MHz_inv, .reset, .inc, .cycle);

	rfo_phase_detect phase_detect_inst (
		.clk10MHz_inv, .reset,
		.cycle, .iq, .target,
		.theta, .theta_valid, .locked
	);

	rfo_freq_ctrl freq_ctrl_inst (
		.clk10MHz_inv, .reset,
		.mode, .load, .start_inc, .sweep_end,
		.theta, .target, .theta_valid,
		.inc, .sweep_done
	);

	rfo_gate_drive gate_drive_inst (
		.clk10MHz_inv, .reset, .cycle, .bridge_en,
		.gate_ap, .gate_an, .gate_bp, .gate_bn
	);

endmodule

//--- verif/rfo_props.sv
`timescale 1ns/1ns

module rfo_props (
	input logic clk10MHz_inv,
	input logic reset,
	input logic bridge_en,
	input logic gate_ap,
	input logic gate_an,
	input logic gate_bp,
	input logic gate_bn
);

	// no shoot-through on either leg
	leg_a_exclusive: assert property (
		@(posedge clk10MHz_inv) disable iff (reset) !(gate_ap && gate_an))
		else $error("leg a high and low side on together");

	leg_b_exclusive: assert property (
		@(posedge clk10MHz_inv) disable iff (reset) !(gate_bp && gate_bn))
		else $error("leg b high and low side on together");

	// bridge off means every switch off
	bridge_off_quiet: assert property (
		@(posedge clk10MHz_inv) disable iff (reset)
		!bridge_en |-> !(gate_ap || gate_an || gate_bp || gate_bn))
		else $error("gate on while bridge disabled");

endmodule

bind rfo_gate_drive rfo_props props_inst (
	.clk10MHz_inv, .reset, .bridge_en,
	.gate_ap, .gate_an, .gate_bp, .gate_bn
);

//--- verif/rfo_tb.sv
`timescale 1ns/1ns
`include "rfo_defs.svh"

module rfo_tb;
	import rfo_pkg::*;

	localparam int dead = `RFO_DEAD_CLKS;

	logic                   clk10MHz_inv = 1'b0;
	logic                   reset;
	logic                   psel;
	logic                   penable;
	logic                   pwrite;
	logic [`RFO_APB_AW-1:0] paddr;
	logic [`RFO_APB_DW-1:0] pwdata;
	logic [`RFO_APB_DW-1:0] prdata;
	logic                   pready;
	logic                   pslverr;
	logic                   iq;
	logic                   fault;
	logic                   gate_ap;
	logic                   gate_an;
	logic                   gate_bp;
	logic                   gate_bn;
	logic                   locked;
	logic [31:0]            lcg_state = 32'hf16c;

	always #50 clk10MHz_inv = ~clk10MHz_inv;  // 10 MHz

	rfo_top rfo_top_inst (
		.clk10MHz_inv, .reset,
		.psel, .penable, .pwrite, .paddr, .pwdata,
		.prdata, .pready, .pslverr,
		.iq, .fault,
		.gate_ap, .gate_an, .gate_bp, .gate_bn,
		.locked
	);

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Result: FAILED");
		$fatal(1);
	endtask

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic cmp_word(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp)
			fail_run($sformatf("mismatch at %0t: %s got 0x%0h expected 0x%0h",
				$time, what, got, exp));
	endtask

	task automatic cmp_inc(input inc_t got, input inc_t exp, input string what);
		if (got !== exp)
			fail_run($sformatf("mismatch at %0t: %s got %0d expected %0d",
				$time, what, got, exp));
	endtask

	task automatic cmp_theta(input theta_t got, input theta_t exp, input string what);
		if (got !== exp)
			fail_run($sformatf("mismatch at %0t: %s got %0d expected %0d",
				$time, what, got, exp));
	endtask

	task automatic cmp_mode(input mode_t got, input mode_t exp, input string what);
		if (got !== exp)
			fail_run($sformatf("mismatch at %0t: %s got mode %0d expected %0d",
				$time, what, got, exp));
	endtask

	// range and flag conditions
	task automatic check_true(input logic ok, input string what);
		if (ok !== 1'b1)
			fail_run($sformatf("mismatch at %0t: %s", $time, what));
	endtask

	task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
			input logic exp_err, output logic [31:0] rdata);
		int waited;
		@(negedge clk10MHz_inv);
		psel    = 1'b1;  // setup
		penable = 1'b0;
		pwrite  = wr;
		paddr   = addr;
		pwdata  = wdata;
		@(negedge clk10MHz_inv);
		penable = 1'b1;  // access
		#10;
		waited = 0;
		while (!pready) begin
			if (waited == 8)
				fail_run($sformatf("apb slave never raised pready at address 0x%0h", addr));
			@(negedge clk10MHz_inv);
			#10;
			waited++;
		end
		rdata = prdata;
		cmp_word({31'd0, pslverr}, {31'd0, exp_err}, $sformatf("pslverr at 0x%0h", addr));
		@(negedge clk10MHz_inv);  // write landed on the rising edge
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
		logic [31:0] unused_rd;
		apb_xfer(1'b1, addr, data, 1'b0, unused_rd);
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
		apb_xfer(1'b0, addr, 32'd0, 1'b0, data);
	endtask

	task automatic wait_mode(input mode_t want, input int max_polls);
		logic [31:0] rd;
		int          polls;
		polls = 0;
		apb_read(`RFO_ADDR_STATUS, rd);
		while (mode_t'(rd[1:0]) != want) begin
			if (polls == max_polls)
				fail_run($sformatf("timed out waiting for mode %0d", want));
			apb_read(`RFO_ADDR_STATUS, rd);
			polls++;
		end
	endtask

	task automatic wait_locked(input logic want, input int max_clks);
		int clks;
		clks = 0;
		while (locked !== want) begin
			if (clks == max_clks)
				fail_run($sformatf("timed out waiting for locked to go %0b", want));
			@(negedge clk10MHz_inv);
			clks++;
		end
	endtask

	task automatic gates_low(input int clks);
		repeat (clks) begin
			@(negedge clk10MHz_inv);
			cmp_word({28'd0, gate_ap, gate_an, gate_bp, gate_bn}, 32'd0, "gates in idle");
		end
	endtask

	task automatic test_reset_regs();
		logic [31:0] rd;
		logic [31:0] r;
		inc_t        v;
		theta_t      t;
		apb_read(`RFO_ADDR_STATUS, rd);
		cmp_mode(mode_t'(rd[1:0]), MODE_IDLE, "mode after reset");
		cmp_word(rd, 32'd0, "status after reset");  // locked low as well
		apb_read(`RFO_ADDR_START_INC, rd);
		cmp_inc(rd[14:0], inc_t'(`RFO_START_INC_RST), "start_inc default");
		apb_read(`RFO_ADDR_SWEEP_END, rd);
		cmp_inc(rd[14:0], inc_t'(`RFO_SWEEP_END_RST), "sweep_end default");
		for (int i = 0; i < 4; i++) begin
			r = next_random();
			v = r[14:0];
			apb_write(`RFO_ADDR_START_INC, {17'd0, v});
			apb_read(`RFO_ADDR_START_INC, rd);
			cmp_inc(rd[14:0], v, "start_inc readback");
			v = r[30:16];
			apb_write(`RFO_ADDR_SWEEP_END, {17'd0, v});
			apb_read(`RFO_ADDR_SWEEP_END, rd);
			cmp_inc(rd[14:0], v, "sweep_end readback");
			t = r[24:16] ^ r[8:0];
			apb_write(`RFO_ADDR_TARGET, {23'd0, t});
			apb_read(`RFO_ADDR_TARGET, rd);
			cmp_theta(rd[8:0], t, "target readback");
			cmp_word(rd, {{23{t[8]}}, t}, "target sign extension");
		end
		apb_write(`RFO_ADDR_CTRL, 32'h2);  // sweep_en only, no start
		apb_read(`RFO_ADDR_CTRL, rd);
		cmp_word(rd, 32'h2, "ctrl readback");
		apb_read(`RFO_ADDR_STATUS, rd);
		cmp_mode(mode_t'(rd[1:0]), MODE_IDLE, "mode without start");
		// bad accesses
		apb_xfer(1'b0, 8'h1C, 32'd0, 1'b1, rd);
		apb_xfer(1'b1, 8'h40, 32'h1, 1'b1, rd);
		apb_xfer(1'b1, `RFO_ADDR_INC, 32'h7fff, 1'b1, rd);
		apb_read(`RFO_ADDR_INC, rd);
		cmp_inc(rd[14:0], inc_t'(`RFO_START_INC_RST), "inc after ro write");
		apb_write(`RFO_ADDR_CTRL, 32'h0);
		apb_write(`RFO_ADDR_START_INC, `RFO_START_INC_RST);
		apb_write(`RFO_ADDR_SWEEP_END, `RFO_SWEEP_END_RST);
		apb_write(`RFO_ADDR_TARGET, 32'd0);
	endtask

	task automatic test_dead_time();
		logic [1:0] p;
		logic [1:0] n;
		int         gap[2];
		int         edges[2];
		logic [1:0] seen_on;
		gap     = '{0, 0};
		edges   = '{0, 0};
		seen_on = 2'b00;
		gates_low(200);
		apb_write(`RFO_ADDR_CTRL, 32'h1);  // straight to track
		for (int i = 0; i < 400; i++) begin
			@(negedge clk10MHz_inv);
			p = {gate_bp, gate_ap};
			n = {gate_bn, gate_an};
			for (int leg = 0; leg < 2; leg++) begin
				if (p[leg] || n[leg]) begin
					if (gap[leg] > 0) begin
						cmp_word(gap[leg], dead, $sformatf("dead time on leg %0d", leg));
						edges[leg]++;
					end
					gap[leg]     = 0;
					seen_on[leg] = 1'b1;
				end else if (seen_on[leg]) begin
					gap[leg]++;  // both off
				end
			end
		end
		check_true(edges[0] >= 4 && edges[1] >= 4,
			$sformatf("too few leg transitions, a %0d b %0d", edges[0], edges[1]));
		apb_write(`RFO_ADDR_CTRL, 32'h0);
		wait_mode(MODE_IDLE, 10);
	endtask

	task automatic test_sweep();
		logic [31:0] rd;
		logic [31:0] r;
		inc_t        s_inc;
		r = next_random();
		// ends the ramp at 1971, a few counts clear of sweep_end
		s_inc = inc_t'(32'd1001 + 32'd10 * (r % 32'd80));
		apb_write(`RFO_ADDR_START_INC, {17'd0, s_inc});
		apb_write(`RFO_ADDR_SWEEP_END, `RFO_SWEEP_END_RST);
		apb_write(`RFO_ADDR_CTRL, 32'h3);
		apb_read(`RFO_ADDR_STATUS, rd);
		cmp_mode(mode_t'(rd[1:0]), MODE_SWEEP, "mode after sweep start");
		wait_mode(MODE_TRACK, 8000);
		apb_read(`RFO_ADDR_INC, rd);
		check_true(rd[14:0] >= inc_t'(`RFO_SWEEP_END_RST),
			$sformatf("inc %0d below sweep end after sweep", rd[14:0]));
		apb_write(`RFO_ADDR_CTRL, 32'h0);
		wait_mode(MODE_IDLE, 10);
	endtask

	task automatic test_lock();
		logic [31:0] rd;
		logic [31:0] r;
		inc_t        s_inc;
		theta_t      t;
		int          d;
		r = next_random();
		s_inc = inc_t'(32'd1200 + (r % 32'd200));
		iq = 1'b0;  // 50 % duty against the drive
		apb_write(`RFO_ADDR_TARGET, 32'd0);
		apb_write(`RFO_ADDR_START_INC, {17'd0, s_inc});
		apb_write(`RFO_ADDR_CTRL, 32'h1);  // first run brings the nco near start_inc
		repeat (200) @(negedge clk10MHz_inv);
		apb_write(`RFO_ADDR_CTRL, 32'h0);
		wait_mode(MODE_IDLE, 10);
		apb_write(`RFO_ADDR_TARGET, 32'd100);  // integrator holds in idle
		wait_locked(1'b0, 2000);
		apb_write(`RFO_ADDR_TARGET, 32'd0);
		apb_write(`RFO_ADDR_CTRL, 32'h1);  // reload start_inc at nearly the same rate
		wait_locked(1'b1, 2000);
		apb_read(`RFO_ADDR_STATUS, rd);
		cmp_mode(mode_t'(rd[1:0]), MODE_TRACK, "mode when locked");
		cmp_word({31'd0, rd[2]}, 32'd1, "status locked bit");
		for (int i = 0; i < 5; i++) begin
			repeat (200) @(negedge clk10MHz_inv);  // a few switching cycles
			apb_read(`RFO_ADDR_INC, rd);
			d = int'(rd[14:0]) - int'(s_inc);
			check_true(d >= -2 && d <= 2,
				$sformatf("inc %0d drifted from start %0d", rd[14:0], s_inc));
			apb_read(`RFO_ADDR_THETA, rd);
			t = rd[8:0];
			check_true(t >= -9'sd1 && t <= 9'sd1, $sformatf("theta %0d not within 1", t));
			cmp_word(rd, {{23{t[8]}}, t}, "theta sign extension");
		end
		apb_write(`RFO_ADDR_TARGET, 32'd100);  // far outside the exit band
		wait_locked(1'b0, 2000);
		apb_read(`RFO_ADDR_INC, rd);
		check_true(rd[14:0] < s_inc,
			$sformatf("inc %0d not below start %0d", rd[14:0], s_inc));
		apb_write(`RFO_ADDR_CTRL, 32'h0);
		wait_mode(MODE_IDLE, 10);
		apb_write(`RFO_ADDR_TARGET, 32'd0);
	endtask

	// bridge off, then lock drops once target moves away
	task automatic check_stopped();
		wait_mode(MODE_IDLE, 10);
		gates_low(100);
		apb_write(`RFO_ADDR_TARGET, 32'd100);  // detector keeps running in idle
		wait_locked(1'b0, 2000);
		apb_write(`RFO_ADDR_TARGET, 32'd0);
	endtask

	task automatic test_stop_fault();
		apb_write(`RFO_ADDR_START_INC, `RFO_START_INC_RST);
		apb_write(`RFO_ADDR_CTRL, 32'h1);
		wait_locked(1'b1, 2000);
		@(negedge clk10MHz_inv);
		fault = 1'b1;
		check_stopped();
		@(negedge clk10MHz_inv);
		fault = 1'b0;  // start still set, back to track
		wait_mode(MODE_TRACK, 10);
		wait_locked(1'b1, 2000);
		apb_write(`RFO_ADDR_CTRL, 32'h0);
		check_stopped();
	endtask

	// shoot-through watch for the whole run
	always @(negedge clk10MHz_inv) begin
		if (!reset && ((gate_ap && gate_an) || (gate_bp && gate_bn)))
			fail_run("both gates of one bridge leg are on together");
	end

	initial begin
		reset   = 1'b1;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = '0;
		pwdata  = '0;
		iq      = 1'b0;
		fault   = 1'b0;
		repeat (8) @(negedge clk10MHz_inv);
		reset = 1'b0;
		test_reset_regs();
		test_dead_time();
		test_sweep();
		test_lock();
		test_stop_fault();
		$display("Result: PASSED");
		$finish;
	end

endmodule

//--- list.f
+incdir+hw
hw/rfo_pkg.sv
hw/rfo_apb_regs.sv
hw/rfo_mode_fsm.sv
hw/rfo_nco.sv
hw/rfo_phase_detect.sv
hw/rfo_freq_ctrl.sv
hw/rfo_gate_drive.sv
hw/rfo_top.sv
verif/rfo_props.sv
verif/rfo_tb.sv

//--- Makefile
VERILATOR    ?= verilator
FILE_LIST    := list.f
TOP          := rfo_tb
OBJ_DIR      := obj_dir
COMMON_FLAGS := --timing --assert -f $(FILE_LIST) --top-module $(TOP)
LINT_FLAGS   := --lint-only
SIM_FLAGS    := --binary -Wno-fatal --Mdir $(OBJ_DIR) -o V$(TOP)
PASS_MSG     := Result: PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(COMMON_FLAGS)

sim:
	$(VERILATOR) $(SIM_FLAGS) $(COMMON_FLAGS)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
